/* rtl/id_pkg.sv */
package id_pkg;

	localparam int XLEN   = 32;
	localparam int REG_AW = 5;
	localparam int OPC_W  = 6;	// opcode and funct width
	localparam int IMM_W  = 16;
	localparam int JIDX_W = 26;

	// field positions in the instruction word
	localparam int OPC_LSB = 26;
	localparam int RS_LSB  = 21;
	localparam int RT_LSB  = 16;
	localparam int RD_LSB  = 11;
	localparam int SA_LSB  = 6;

	localparam logic [REG_AW-1:0] LINK_REG    = 5'd31;
	localparam logic [XLEN-1:0]   LINK_OFFSET = 32'd8;	// return past the delay slot

	typedef enum logic [OPC_W-1:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
		OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
		OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
		OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
		OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [OPC_W-1:0] {
		FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03, FN_SLLV = 6'h04,
		FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_JR   = 6'h08, FN_JALR = 6'h09,
		FN_ADD  = 6'h20, FN_ADDU = 6'h21, FN_SUB  = 6'h22, FN_SUBU = 6'h23,
		FN_AND  = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
	} funct_e;

	// bit 4 of the rt code marks the linking forms
	typedef enum logic [REG_AW-1:0] {
		RI_BLTZ   = 5'h00,
		RI_BGEZ   = 5'h01,
		RI_BLTZAL = 5'h10,
		RI_BGEZAL = 5'h11
	} regimm_e;

	typedef enum logic [3:0] {
		ALU_NOP = 4'd0, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
		ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE = 4'd0, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
	} mem_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_REL,	// pc relative
		BR_ABS,	// 26-bit jump index
		BR_REG
	} br_kind_e;

endpackage

/* rtl/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder
	import id_pkg::*;
(
	input  logic              if_flush_i,
	input  logic [XLEN-1:0]   inst_i,
	output logic [REG_AW-1:0] reg1addr_o,
	output logic [REG_AW-1:0] reg2addr_o,
	output logic              ren1_o,
	output logic              ren2_o,
	output br_kind_e          br_kind_o,
	output logic [OPC_W-1:0]  br_cond_o,
	output logic              src1_is_sa_o,
	output logic              src1_is_pc_o,
	output logic              src2_is_imm_s_o,
	output logic              src2_is_imm_u_o,
	output logic              src2_is_8_o,
	output logic              waddr_is_31_o,
	output logic              waddr_is_rt_o,
	output alu_op_e           alu_op_o,
	output mem_op_e           mem_op_o,
	output logic              wren_o,
	output logic              nofwd_o
);

	logic [XLEN-1:0]   inst;
	opcode_e           opcode;
	funct_e            funct;
	regimm_e           rt_code;
	logic [REG_AW-1:0] rs;
	logic [REG_AW-1:0] rt;
	logic [REG_AW-1:0] rd;
	logic [REG_AW-1:0] sa;
	logic              nop;
	alu_op_e           r_op;
	logic              alu_imm;
	logic              load;
	logic              store;
	logic              link;

	assign inst    = if_flush_i ? '0 : inst_i;	// squashed slot decodes as nop
	assign opcode  = opcode_e'(inst[OPC_LSB +: OPC_W]);
	assign funct   = funct_e'(inst[OPC_W-1:0]);
	assign rs      = inst[RS_LSB +: REG_AW];
	assign rt      = inst[RT_LSB +: REG_AW];
	assign rd      = inst[RD_LSB +: REG_AW];
	assign sa      = inst[SA_LSB +: REG_AW];
	assign rt_code = regimm_e'(rt);
	assign nop     = (inst == '0);

	assign reg1addr_o = rs;
	assign reg2addr_o = rt;

	always_comb begin
		case (funct)
			FN_ADD, FN_ADDU: r_op = ALU_ADD;
			FN_SUB, FN_SUBU: r_op = ALU_SUB;
			FN_SLT:          r_op = ALU_SLT;
			FN_SLTU:         r_op = ALU_SLTU;
			FN_AND:          r_op = ALU_AND;
			FN_OR:           r_op = ALU_OR;
			FN_XOR:          r_op = ALU_XOR;
			FN_NOR:          r_op = ALU_NOR;
			FN_SLL, FN_SLLV: r_op = ALU_SLL;
			FN_SRL, FN_SRLV: r_op = ALU_SRL;
			FN_SRA, FN_SRAV: r_op = ALU_SRA;
			default:         r_op = ALU_NOP;	// jr, jalr and unknown codes
		endcase
	end

	always_comb begin
		alu_op_o        = ALU_NOP;
		mem_op_o        = MEM_NONE;
		br_kind_o       = BR_NONE;
		br_cond_o       = '0;
		ren1_o          = 1'b0;
		ren2_o          = 1'b0;
		src1_is_sa_o    = 1'b0;
		src1_is_pc_o    = 1'b0;
		src2_is_imm_s_o = 1'b0;
		src2_is_imm_u_o = 1'b0;
		src2_is_8_o     = 1'b0;
		waddr_is_31_o   = 1'b0;
		waddr_is_rt_o   = 1'b0;
		wren_o          = 1'b0;
		nofwd_o         = 1'b0;
		alu_imm         = 1'b0;
		load            = 1'b0;
		store           = 1'b0;
		link            = 1'b0;

		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_SLL, FN_SRL, FN_SRA: if (rs == '0 && !nop) begin
						alu_op_o     = r_op;
						src1_is_sa_o = 1'b1;
						ren2_o       = 1'b1;
						wren_o       = 1'b1;
					end
					FN_JR: if (rt == '0 && rd == '0 && sa == '0) begin
						br_kind_o = BR_REG;
						ren1_o    = 1'b1;
					end
					FN_JALR: if (rt == '0 && sa == '0) begin
						br_kind_o = BR_REG;
						ren1_o    = 1'b1;
						link      = 1'b1;
					end
					default: if (sa == '0 && r_op != ALU_NOP) begin
						alu_op_o = r_op;
						ren1_o   = 1'b1;
						ren2_o   = 1'b1;
						wren_o   = 1'b1;	// writes rd
					end
				endcase
			end
			OP_REGIMM: if (rt_code inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL}) begin
				br_kind_o = BR_REL;
				br_cond_o = {1'b0, rt};
				ren1_o    = 1'b1;
				link      = rt[4];
			end
			OP_J: br_kind_o = BR_ABS;
			OP_JAL: begin
				br_kind_o = BR_ABS;
				link      = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				br_kind_o = BR_REL;
				br_cond_o = opcode;
				ren1_o    = 1'b1;
				ren2_o    = 1'b1;
			end
			OP_BLEZ, OP_BGTZ: if (rt == '0) begin
				br_kind_o = BR_REL;
				br_cond_o = opcode;
				ren1_o    = 1'b1;
			end
			OP_ADDI, OP_ADDIU: begin
				alu_op_o        = ALU_ADD;
				src2_is_imm_s_o = 1'b1;
				alu_imm         = 1'b1;
			end
			OP_SLTI: begin
				alu_op_o        = ALU_SLT;
				src2_is_imm_s_o = 1'b1;
				alu_imm         = 1'b1;
			end
			OP_SLTIU: begin
				alu_op_o        = ALU_SLTU;
				src2_is_imm_s_o = 1'b1;
				alu_imm         = 1'b1;
			end
			OP_ANDI: begin
				alu_op_o        = ALU_AND;
				src2_is_imm_u_o = 1'b1;
				alu_imm         = 1'b1;
			end
			OP_ORI: begin
				alu_op_o        = ALU_OR;
				src2_is_imm_u_o = 1'b1;
				alu_imm         = 1'b1;
			end
			OP_XORI: begin
				alu_op_o        = ALU_XOR;
				src2_is_imm_u_o = 1'b1;
				alu_imm         = 1'b1;
			end
			OP_LUI: if (rs == '0) begin
				alu_op_o        = ALU_LUI;
				src2_is_imm_u_o = 1'b1;
				alu_imm         = 1'b1;
			end
			OP_LB: begin
				mem_op_o = MEM_LB;
				load     = 1'b1;
			end
			OP_LBU: begin
				mem_op_o = MEM_LBU;
				load     = 1'b1;
			end
			OP_LH: begin
				mem_op_o = MEM_LH;
				load     = 1'b1;
			end
			OP_LHU: begin
				mem_op_o = MEM_LHU;
				load     = 1'b1;
			end
			OP_LW: begin
				mem_op_o = MEM_LW;
				load     = 1'b1;
			end
			OP_SB: begin
				mem_op_o = MEM_SB;
				store    = 1'b1;
			end
			OP_SH: begin
				mem_op_o = MEM_SH;
				store    = 1'b1;
			end
			OP_SW: begin
				mem_op_o = MEM_SW;
				store    = 1'b1;
			end
			default: ;
		endcase

		if (alu_imm) begin
			ren1_o        = (opcode != OP_LUI);
			waddr_is_rt_o = 1'b1;
			wren_o        = 1'b1;
		end
		if (load || store) begin
			alu_op_o        = ALU_ADD;	// address calc
			src2_is_imm_s_o = 1'b1;
			ren1_o          = 1'b1;
		end
		if (load) begin
			waddr_is_rt_o = 1'b1;
			wren_o        = 1'b1;
			nofwd_o       = 1'b1;	// data only after mem
		end
		if (store)
			ren2_o = 1'b1;
		if (link) begin
			alu_op_o      = ALU_ADD;	// pc + 8
			src1_is_pc_o  = 1'b1;
			src2_is_8_o   = 1'b1;
			waddr_is_31_o = 1'b1;
			wren_o        = 1'b1;
		end
	end

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit
	import id_pkg::*;
(
	input  logic [XLEN-1:0]  pc_i,
	input  logic [XLEN-1:0]  inst_i,
	input  logic [XLEN-1:0]  reg1data_i,
	input  logic [XLEN-1:0]  reg2data_i,
	input  br_kind_e         br_kind_i,
	input  logic [OPC_W-1:0] br_cond_i,
	output logic             branch_en_o,
	output logic [XLEN-1:0]  branch_pc_o,
	output logic             next_inslot_o
);

	logic [XLEN-1:0] pcp4;
	logic [XLEN-1:0] rel_target;
	logic [XLEN-1:0] abs_target;
	logic            eq;
	logic            ltz;
	logic            lez;
	logic            cond;

	assign pcp4       = pc_i + 32'd4;
	assign rel_target = pcp4 + {{(XLEN-IMM_W-2){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0], 2'b00};
	assign abs_target = {pcp4[XLEN-1 -: 4], inst_i[JIDX_W-1:0], 2'b00};

	assign eq  = (reg1data_i == reg2data_i);
	assign ltz = reg1data_i[XLEN-1];
	assign lez = ltz || (reg1data_i == '0);

	// regimm codes sit in the low five bits, clear of the opcode values
	always_comb begin
		case (br_cond_i)
			OP_BEQ:                              cond = eq;
			OP_BNE:                              cond = ~eq;
			OP_BLEZ:                             cond = lez;
			OP_BGTZ:                             cond = ~lez;
			{1'b0, RI_BLTZ}, {1'b0, RI_BLTZAL}: cond = ltz;
			{1'b0, RI_BGEZ}, {1'b0, RI_BGEZAL}: cond = ~ltz;
			default:                             cond = 1'b0;
		endcase
	end

	always_comb begin
		case (br_kind_i)
			BR_REL: begin
				branch_en_o = cond;
				branch_pc_o = rel_target;
			end
			BR_ABS: begin
				branch_en_o = 1'b1;
				branch_pc_o = abs_target;
			end
			default: begin
				branch_en_o = (br_kind_i == BR_REG);
				branch_pc_o = reg1data_i;
			end
		endcase
	end

	assign next_inslot_o = (br_kind_i != BR_NONE);	// delay slot even when not taken

endmodule

/* rtl/operand_select.sv */
`timescale 1ns/100ps

module operand_select
	import id_pkg::*;
(
	input  logic [XLEN-1:0]   pc_i,
	input  logic [XLEN-1:0]   inst_i,
	input  logic [XLEN-1:0]   reg1data_i,
	input  logic [XLEN-1:0]   reg2data_i,
	input  logic              src1_is_sa_i,
	input  logic              src1_is_pc_i,
	input  logic              src2_is_imm_s_i,
	input  logic              src2_is_imm_u_i,
	input  logic              src2_is_8_i,
	input  logic              waddr_is_31_i,
	input  logic              waddr_is_rt_i,
	output logic [XLEN-1:0]   opr1_o,
	output logic [XLEN-1:0]   opr2_o,
	output logic [XLEN-1:0]   offset_o,
	output logic [REG_AW-1:0] waddr_o
);

	logic [XLEN-1:0]   sign_ext;
	logic [XLEN-1:0]   zero_ext;
	logic [XLEN-1:0]   sa_ext;
	logic [REG_AW-1:0] rt;
	logic [REG_AW-1:0] rd;

	assign sign_ext = {{(XLEN-IMM_W){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0]};
	assign zero_ext = {{(XLEN-IMM_W){1'b0}}, inst_i[IMM_W-1:0]};
	assign sa_ext   = {{(XLEN-REG_AW){1'b0}}, inst_i[SA_LSB +: REG_AW]};
	assign rt       = inst_i[RT_LSB +: REG_AW];
	assign rd       = inst_i[RD_LSB +: REG_AW];

	assign opr1_o = src1_is_sa_i ? sa_ext :
			src1_is_pc_i ? pc_i :
			reg1data_i;

	assign opr2_o = src2_is_imm_s_i ? sign_ext :
			src2_is_imm_u_i ? zero_ext :	// lui shifts this in ex
			src2_is_8_i     ? LINK_OFFSET :
			reg2data_i;

	assign waddr_o = waddr_is_31_i ? LINK_REG :
			 waddr_is_rt_i ? rt :
			 rd;

	assign offset_o = sign_ext;	// load/store displacement

endmodule

/* rtl/id_ex_reg.sv */
`timescale 1ns/100ps

module id_ex_reg
	import id_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              stall_i,
	input  logic              flush_i,
	input  logic [XLEN-1:0]   pc_i,
	input  logic [XLEN-1:0]   opr1_i,
	input  logic [XLEN-1:0]   opr2_i,
	input  logic [XLEN-1:0]   offset_i,
	input  logic [XLEN-1:0]   rtvalue_i,
	input  logic [REG_AW-1:0] waddr_i,
	input  logic              wren_i,
	input  alu_op_e           alu_op_i,
	input  mem_op_e           mem_op_i,
	input  logic              nofwd_i,
	output logic [XLEN-1:0]   pc_o,
	output logic [XLEN-1:0]   opr1_o,
	output logic [XLEN-1:0]   opr2_o,
	output logic [XLEN-1:0]   offset_o,
	output logic [XLEN-1:0]   rtvalue_o,
	output logic [REG_AW-1:0] waddr_o,
	output logic              wren_o,
	output alu_op_e           alu_op_o,
	output mem_op_e           mem_op_o,
	output logic              nofwd_o
);

	logic bubble;

	// stall wins over flush, reset wins over both
	assign bubble = !rst_n_i || (flush_i && !stall_i);

	always_ff @(posedge clk) begin
		if (bubble) begin
			pc_o      <= '0;
			opr1_o    <= '0;
			opr2_o    <= '0;
			offset_o  <= '0;
			rtvalue_o <= '0;
			waddr_o   <= '0;
			wren_o    <= 1'b0;
			alu_op_o  <= ALU_NOP;
			mem_op_o  <= MEM_NONE;
			nofwd_o   <= 1'b0;
		end else if (!stall_i) begin
			pc_o      <= pc_i;
			opr1_o    <= opr1_i;
			opr2_o    <= opr2_i;
			offset_o  <= offset_i;
			rtvalue_o <= rtvalue_i;	// store data
			waddr_o   <= waddr_i;
			wren_o    <= wren_i;
			alu_op_o  <= alu_op_i;
			mem_op_o  <= mem_op_i;
			nofwd_o   <= nofwd_i;
		end
	end

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/100ps

module id_stage
	import id_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              if_flush_i,
	input  logic              id_flush_i,
	input  logic              id_stall_i,
	input  logic [XLEN-1:0]   id_pc_i,
	input  logic [XLEN-1:0]   id_inst_i,
	input  logic [XLEN-1:0]   id_reg1data_i,
	input  logic [XLEN-1:0]   id_reg2data_i,
	output logic [REG_AW-1:0] id_reg1addr_o,
	output logic [REG_AW-1:0] id_reg2addr_o,
	output logic              id_ren1_o,
	output logic              id_ren2_o,
	output logic              id_branch_en_o,
	output logic [XLEN-1:0]   id_branch_pc_o,
	output logic              id_next_inslot_o,
	output logic [XLEN-1:0]   id_pc_o,
	output logic [XLEN-1:0]   id_opr1_o,
	output logic [XLEN-1:0]   id_opr2_o,
	output logic [XLEN-1:0]   id_offset_o,
	output logic [XLEN-1:0]   id_rtvalue_o,
	output logic              id_wren_o,
	output logic [REG_AW-1:0] id_waddr_o,
	output alu_op_e           id_aluop_o,
	output mem_op_e           id_memop_o,
	output logic              id_nofwd_o
);

	br_kind_e          br_kind;
	logic [OPC_W-1:0]  br_cond;
	logic              src1_is_sa;
	logic              src1_is_pc;
	logic              src2_is_imm_s;
	logic              src2_is_imm_u;
	logic              src2_is_8;
	logic              waddr_is_31;
	logic              waddr_is_rt;
	alu_op_e           alu_op;
	mem_op_e           mem_op;
	logic              wren;
	logic              nofwd;
	logic [XLEN-1:0]   opr1;
	logic [XLEN-1:0]   opr2;
	logic [XLEN-1:0]   offset;
	logic [REG_AW-1:0] waddr;

	inst_decoder inst_decoder_inst (
		.if_flush_i      (if_flush_i),
		.inst_i          (id_inst_i),
		.reg1addr_o      (id_reg1addr_o),
		.reg2addr_o      (id_reg2addr_o),
		.ren1_o          (id_ren1_o),
		.ren2_o          (id_ren2_o),
		.br_kind_o       (br_kind),
		.br_cond_o       (br_cond),
		.src1_is_sa_o    (src1_is_sa),
		.src1_is_pc_o    (src1_is_pc),
		.src2_is_imm_s_o (src2_is_imm_s),
		.src2_is_imm_u_o (src2_is_imm_u),
		.src2_is_8_o     (src2_is_8),
		.waddr_is_31_o   (waddr_is_31),
		.waddr_is_rt_o   (waddr_is_rt),
		.alu_op_o        (alu_op),
		.mem_op_o        (mem_op),
		.wren_o          (wren),
		.nofwd_o         (nofwd)
	);

	branch_unit branch_unit_inst (
		.pc_i          (id_pc_i),
		.inst_i        (id_inst_i),
		.reg1data_i    (id_reg1data_i),
		.reg2data_i    (id_reg2data_i),
		.br_kind_i     (br_kind),
		.br_cond_i     (br_cond),
		.branch_en_o   (id_branch_en_o),
		.branch_pc_o   (id_branch_pc_o),
		.next_inslot_o (id_next_inslot_o)
	);

	operand_select operand_select_inst (
		.pc_i            (id_pc_i),
		.inst_i          (id_inst_i),
		.reg1data_i      (id_reg1data_i),
		.reg2data_i      (id_reg2data_i),
		.src1_is_sa_i    (src1_is_sa),
		.src1_is_pc_i    (src1_is_pc),
		.src2_is_imm_s_i (src2_is_imm_s),
		.src2_is_imm_u_i (src2_is_imm_u),
		.src2_is_8_i     (src2_is_8),
		.waddr_is_31_i   (waddr_is_31),
		.waddr_is_rt_i   (waddr_is_rt),
		.opr1_o          (opr1),
		.opr2_o          (opr2),
		.offset_o        (offset),
		.waddr_o         (waddr)
	);

	id_ex_reg id_ex_reg_inst (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.stall_i   (id_stall_i),
		.flush_i   (id_flush_i),
		.pc_i      (id_pc_i),
		.opr1_i    (opr1),
		.opr2_i    (opr2),
		.offset_i  (offset),
		.rtvalue_i (id_reg2data_i),
		.waddr_i   (waddr),
		.wren_i    (wren),
		.alu_op_i  (alu_op),
		.mem_op_i  (mem_op),
		.nofwd_i   (nofwd),
		.pc_o      (id_pc_o),
		.opr1_o    (id_opr1_o),
		.opr2_o    (id_opr2_o),
		.offset_o  (id_offset_o),
		.rtvalue_o (id_rtvalue_o),
		.waddr_o   (id_waddr_o),
		.wren_o    (id_wren_o),
		.alu_op_o  (id_aluop_o),
		.mem_op_o  (id_memop_o),
		.nofwd_o   (id_nofwd_o)
	);

endmodule

/* verification/id_stage_props.sv */
`timescale 1ns/100ps

module id_stage_props
	import id_pkg::*;
(
	input logic              clk,
	input logic              rst_n_i,
	input logic              stall_i,
	input logic              branch_en_i,
	input logic              next_inslot_i,
	input logic [XLEN-1:0]   pc_i,
	input logic [XLEN-1:0]   opr1_i,
	input logic [XLEN-1:0]   opr2_i,
	input logic [XLEN-1:0]   offset_i,
	input logic [XLEN-1:0]   rtvalue_i,
	input logic [REG_AW-1:0] waddr_i,
	input logic              wren_i,
	input alu_op_e           aluop_i,
	input mem_op_e           memop_i,
	input logic              nofwd_i
);

	logic is_bubble;

	assign is_bubble = (pc_i == '0) && (opr1_i == '0) && (opr2_i == '0) && (offset_i == '0) &&
		(rtvalue_i == '0) && (waddr_i == '0) && !wren_i && !nofwd_i &&
		(aluop_i == ALU_NOP) && (memop_i == MEM_NONE);

	reset_bubble: assert property (@(posedge clk) !rst_n_i |=> is_bubble)
		else $error("ID/EX outputs not a bubble after reset");

	stall_hold: assert property (@(posedge clk)
		rst_n_i && stall_i |=> $stable(opr1_i) && $stable(wren_i))
		else $error("ID/EX outputs changed under stall");

	taken_in_slot: assert property (@(posedge clk) branch_en_i |-> next_inslot_i)
		else $error("branch taken without delay slot flag");

endmodule

bind id_stage id_stage_props id_stage_props_inst (
	.clk           (clk),
	.rst_n_i       (rst_n_i),
	.stall_i       (id_stall_i),
	.branch_en_i   (id_branch_en_o),
	.next_inslot_i (id_next_inslot_o),
	.pc_i          (id_pc_o),
	.opr1_i        (id_opr1_o),
	.opr2_i        (id_opr2_o),
	.offset_i      (id_offset_o),
	.rtvalue_i     (id_rtvalue_o),
	.waddr_i       (id_waddr_o),
	.wren_i        (id_wren_o),
	.aluop_i       (id_aluop_o),
	.memop_i       (id_memop_o),
	.nofwd_i       (id_nofwd_o)
);

/* verification/id_stage_tb.sv */
`timescale 1ns/100ps

module id_stage_tb
	import id_pkg::*;
();

	localparam string STIM_FILE = "verification/id_stimulus.txt";
	localparam int    NFIELD    = 20;
	localparam int    MEM_WORDS = 2048;
	localparam int    MAX_LINES = 100;

	// columns of a stimulus line
	localparam int C_PC    = 0;
	localparam int C_INST  = 1;
	localparam int C_R1    = 2;
	localparam int C_R2    = 3;
	localparam int C_STALL = 4;
	localparam int C_FLUSH = 5;
	localparam int C_IFFL  = 6;
	localparam int C_BEN   = 7;
	localparam int C_BPC   = 8;
	localparam int C_SLOT  = 9;
	localparam int C_REN1  = 10;
	localparam int C_REN2  = 11;
	localparam int C_OPR1  = 12;
	localparam int C_OPR2  = 13;
	localparam int C_OFF   = 14;
	localparam int C_WADDR = 15;
	localparam int C_WREN  = 16;
	localparam int C_ALU   = 17;
	localparam int C_MEM   = 18;
	localparam int C_NOFWD = 19;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              if_flush;
	logic              id_flush;
	logic              id_stall;
	logic [XLEN-1:0]   id_pc;
	logic [XLEN-1:0]   id_inst;
	logic [XLEN-1:0]   reg1data;
	logic [XLEN-1:0]   reg2data;
	logic [REG_AW-1:0] reg1addr;
	logic [REG_AW-1:0] reg2addr;
	logic              ren1;
	logic              ren2;
	logic              branch_en;
	logic [XLEN-1:0]   branch_pc;
	logic              next_inslot;
	logic [XLEN-1:0]   ex_pc;
	logic [XLEN-1:0]   opr1;
	logic [XLEN-1:0]   opr2;
	logic [XLEN-1:0]   offset;
	logic [XLEN-1:0]   rtvalue;
	logic              wren;
	logic [REG_AW-1:0] waddr;
	alu_op_e           aluop;
	mem_op_e           memop;
	logic              nofwd;

	logic [31:0] stim [0:MEM_WORDS-1];
	int          n_lines = 0;
	int          check_errors = 0;
	int          setup_errors = 0;

	// model of the ID/EX register contents
	logic [31:0] exp_pc;
	logic [31:0] exp_opr1;
	logic [31:0] exp_opr2;
	logic [31:0] exp_offset;
	logic [31:0] exp_rtvalue;
	logic [31:0] exp_waddr;
	logic [31:0] exp_wren;
	logic [31:0] exp_aluop;
	logic [31:0] exp_memop;
	logic [31:0] exp_nofwd;

	always #2 clk = ~clk;

	id_stage id_stage_inst (
		.clk              (clk),
		.rst_n_i          (rst_n),
		.if_flush_i       (if_flush),
		.id_flush_i       (id_flush),
		.id_stall_i       (id_stall),
		.id_pc_i          (id_pc),
		.id_inst_i        (id_inst),
		.id_reg1data_i    (reg1data),
		.id_reg2data_i    (reg2data),
		.id_reg1addr_o    (reg1addr),
		.id_reg2addr_o    (reg2addr),
		.id_ren1_o        (ren1),
		.id_ren2_o        (ren2),
		.id_branch_en_o   (branch_en),
		.id_branch_pc_o   (branch_pc),
		.id_next_inslot_o (next_inslot),
		.id_pc_o          (ex_pc),
		.id_opr1_o        (opr1),
		.id_opr2_o        (opr2),
		.id_offset_o      (offset),
		.id_rtvalue_o     (rtvalue),
		.id_wren_o        (wren),
		.id_waddr_o       (waddr),
		.id_aluop_o       (aluop),
		.id_memop_o       (memop),
		.id_nofwd_o       (nofwd)
	);

	function automatic logic [31:0] field(input int line, input int col);
		logic [10:0] idx;
		idx = 11'(line * NFIELD + col);
		return stim[idx];
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
		end
	endtask

	task automatic clear_expected();
		exp_pc      = '0;
		exp_opr1    = '0;
		exp_opr2    = '0;
		exp_offset  = '0;
		exp_rtvalue = '0;
		exp_waddr   = '0;
		exp_wren    = '0;
		exp_aluop   = 32'(ALU_NOP);
		exp_memop   = 32'(MEM_NONE);
		exp_nofwd   = '0;
	endtask

	task automatic check_registered();
		check_val("id_pc_o", exp_pc, ex_pc);
		check_val("id_opr1_o", exp_opr1, opr1);
		check_val("id_opr2_o", exp_opr2, opr2);
		check_val("id_offset_o", exp_offset, offset);
		check_val("id_rtvalue_o", exp_rtvalue, rtvalue);
		check_val("id_waddr_o", exp_waddr, 32'(waddr));
		check_val("id_wren_o", exp_wren, 32'(wren));
		check_val("id_aluop_o", exp_aluop, 32'(aluop));
		check_val("id_memop_o", exp_memop, 32'(memop));
		check_val("id_nofwd_o", exp_nofwd, 32'(nofwd));
	endtask

	task automatic drive_line(input int l);
		id_pc    = field(l, C_PC);
		id_inst  = field(l, C_INST);
		id_stall = (field(l, C_STALL) != 0);
		id_flush = (field(l, C_FLUSH) != 0);
		if_flush = (field(l, C_IFFL) != 0);
		if (id_flush) begin
			reg1data = $urandom;	// never reaches the register
			reg2data = $urandom;
		end else begin
			reg1data = field(l, C_R1);
			reg2data = field(l, C_R2);
		end
	endtask

	task automatic check_comb(input int l);
		logic [31:0] word;
		word = (field(l, C_IFFL) != 0) ? '0 : field(l, C_INST);	// squashed slot reads as zero
		check_val("id_branch_en_o", field(l, C_BEN), 32'(branch_en));
		check_val("id_next_inslot_o", field(l, C_SLOT), 32'(next_inslot));
		check_val("id_ren1_o", field(l, C_REN1), 32'(ren1));
		check_val("id_ren2_o", field(l, C_REN2), 32'(ren2));
		check_val("id_reg1addr_o", 32'(word[25:21]), 32'(reg1addr));	// rs
		check_val("id_reg2addr_o", 32'(word[20:16]), 32'(reg2addr));	// rt
		if (field(l, C_SLOT) != 0)
			check_val("id_branch_pc_o", field(l, C_BPC), branch_pc);
	endtask

	// what the next rising edge should load
	task automatic update_expected(input int l);
		if (!id_stall) begin
			if (id_flush) begin
				clear_expected();
			end else begin
				exp_pc      = field(l, C_PC);
				exp_opr1    = field(l, C_OPR1);
				exp_opr2    = field(l, C_OPR2);
				exp_offset  = field(l, C_OFF);
				exp_rtvalue = reg2data;
				exp_waddr   = field(l, C_WADDR);
				exp_wren    = field(l, C_WREN);
				exp_aluop   = field(l, C_ALU);
				exp_memop   = field(l, C_MEM);
				exp_nofwd   = field(l, C_NOFWD);
			end
		end
	endtask

	initial begin
		int fd;
		int i;
		void'($urandom(5));
		rst_n    = 1'b0;
		if_flush = 1'b0;
		id_flush = 1'b0;
		id_stall = 1'b0;
		id_pc    = '0;
		id_inst  = '0;
		reg1data = '0;
		reg2data = '0;
		clear_expected();

		// words the file leaves alone keep a marker no stall column can hold
		for (i = 0; i < MEM_WORDS; i++)
			stim[i] = {16'hdead, 16'(i)};

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			setup_errors++;
			$display("could not open the stimulus file %s", STIM_FILE);
		end else begin
			$fclose(fd);
			$readmemh(STIM_FILE, stim);
			while (n_lines < MAX_LINES && field(n_lines, C_STALL) <= 1)
				n_lines++;
			if (n_lines == 0) begin
				setup_errors++;
				$display("the stimulus file holds no vector lines");
			end
		end

		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (i = 0; i < n_lines; i++) begin
			check_registered();
			drive_line(i);
			#1;
			check_comb(i);
			update_expected(i);
			@(negedge clk);
		end
		check_registered();

		$display("lines run: %0d, check failures: %0d, setup errors: %0d",
			n_lines, check_errors, setup_errors);
		if (check_errors == 0 && setup_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		wait (n_lines > 0);
		#((n_lines + 20) * 4);
		$display("watchdog expired before the test sequence finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verification/id_stimulus.txt */
// pc inst reg1data reg2data stall id_flush if_flush | branch_en branch_pc next_inslot ren1 ren2
// after the edge: opr1 opr2 offset waddr wren aluop memop nofwd (pc follows the pc column)
00400000 00221820 00000011 00000022 0 0 0 0 00000000 0 1 1 00000011 00000022 00001820 03 1 1 0 0
00400004 00A62022 80000000 00000001 0 0 0 0 00000000 0 1 1 80000000 00000001 00002022 04 1 2 0 0
00400008 016C5027 0f0f0f0f 00ff00ff 0 0 0 0 00000000 0 1 1 0f0f0f0f 00ff00ff 00005027 0a 1 6 0 0
0040000c 000E6900 12345678 0000000f 0 0 0 0 00000000 0 0 1 00000004 0000000f 00006900 0d 1 9 0 0
00400010 00107FC3 aaaaaaaa 80000000 0 0 0 0 00000000 0 0 1 0000001f 80000000 00007fc3 0f 1 b 0 0
00400014 2031FFFC 00000100 deadbeef 0 0 0 0 00000000 0 1 0 00000100 fffffffc fffffffc 11 1 1 0 0
00400018 28528000 00000003 00000000 0 0 0 0 00000000 0 1 0 00000003 ffff8000 ffff8000 12 1 3 0 0
0040001c 3073FF00 1234abcd 00000000 0 0 0 0 00000000 0 1 0 1234abcd 0000ff00 ffffff00 13 1 5 0 0
00400020 3C148001 55555555 00000000 0 0 0 0 00000000 0 0 0 55555555 00008001 ffff8001 14 1 c 0 0
// loads and stores
00400024 8CB6FFF8 10000000 00000000 0 0 0 0 00000000 0 1 0 10000000 fffffff8 fffffff8 16 1 1 5 1
00400028 90D77FFF 20000000 00000000 0 0 0 0 00000000 0 1 0 20000000 00007fff 00007fff 17 1 1 2 1
0040002c A4F80006 30000000 0000beef 0 0 0 0 00000000 0 1 1 30000000 00000006 00000006 00 0 1 7 0
// branches and jumps
00400030 10220004 00000007 00000007 0 0 0 1 00400044 1 1 1 00000007 00000007 00000004 00 0 0 0 0
00400034 1464FFFE 00000009 00000009 0 0 0 0 00400030 1 1 1 00000009 00000009 fffffffe 1f 0 0 0 0
00400038 04B10100 00000000 12345678 0 0 0 1 0040043c 1 1 0 00400038 00000008 00000100 1f 1 1 0 0
0040003c 18C0FFFF fffffff0 00000000 0 0 0 1 0040003c 1 1 0 fffffff0 00000000 ffffffff 1f 0 0 0 0
00400040 0C100040 00000000 00000000 0 0 0 1 00400100 1 0 0 00400040 00000008 00000040 1f 1 1 0 0
9000fffc 0BFFFFFF 00000000 00000000 0 0 0 1 9ffffffc 1 0 0 00000000 00000000 ffffffff 1f 0 0 0 0
00400044 01201009 00401234 00000000 0 0 0 1 00401234 1 1 0 00400044 00000008 00001009 1f 1 1 0 0
00400048 03E00008 00400100 00000000 0 0 0 1 00400100 1 1 0 00400100 00000000 00000008 00 0 0 0 0
// stall, flush bubble, squashed slot
0040004c 00221820 00000001 00000002 1 0 0 0 00000000 0 1 1 00000001 00000002 00001820 03 1 1 0 0
0040004c 00221820 00000001 00000002 0 0 0 0 00000000 0 1 1 00000001 00000002 00001820 03 1 1 0 0
00400050 34050055 00000000 00000000 0 1 0 0 00000000 0 1 0 00000000 00000000 00000000 00 0 0 0 0
00400054 AD28000C 00000000 00000000 1 1 0 0 00000000 0 1 1 00000000 00000000 00000000 00 0 0 0 0
00400058 10220004 00000005 00000005 0 0 1 0 00000000 0 0 0 00000005 00000005 00000004 00 0 0 0 0
0040005c A041FFFF 00001000 000000ab 0 0 0 0 00000000 0 1 1 00001000 ffffffff ffffffff 1f 0 1 6 0

/* files.f */
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/branch_unit.sv
rtl/operand_select.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
verification/id_stage_props.sv
verification/id_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ID stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module id_stage_tb -f files.f -o id_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/id_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
	echo "no result line found in $LOG"
	exit 1
fi
exit 0
